//--- Bender.yml
package:
  name: dsp_iq_shaper

export_include_dirs:
  - common

sources:
  - common/dsp_pkg.sv
  - common/coeff_pkg.sv
  - source/reset_sync.sv
  - source/upsampler.sv
  - fir_filter/fir_filter.sv
  - source/coeff_bank_decoder.sv
  - source/output_gate.sv
  - source/dsp_top.sv
  - target: test
    files:
      - verif/dsp_tb.sv

//--- common/coeff_pkg.sv
`include "dsp_params.svh"

package coeff_pkg;

    // Access type seen by one coefficient bank
    typedef enum logic [1:0] {
        COEFF_NOP   = 2'd0,
        COEFF_READ  = 2'd1,
        COEFF_WRITE = 2'd2
    } coeff_op_e;

    // Request to a single bank, index is already local to the bank
    typedef struct packed {
        coeff_op_e                   op;
        logic [`DSP_TAP_ADDR_W-1:0]  idx;
        logic [`DSP_COEFF_W-1:0]     wdata;
    } coeff_req_t;

endpackage

//--- common/dsp_params.svh
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

// Datapath widths
`define DSP_SAMPLE_W    4
`define DSP_COEFF_W     8
`define DSP_ACC_W       16
`define DSP_DAC_W       10

// Coefficient address map
`define DSP_ADDR_W      10
`define DSP_NUM_TAPS    16
`define DSP_TAP_ADDR_W  4
`define DSP_I_BASE      128
`define DSP_Q_BASE      256

// Input register, tap register and sum register, then a full tap line
`define DSP_FILL_CYCLES (`DSP_NUM_TAPS + 3)

`endif

//--- common/dsp_pkg.sv
`include "dsp_params.svh"

package dsp_pkg;

    // One I/Q pair of baseband samples
    typedef struct packed {
        logic signed [`DSP_SAMPLE_W-1:0] i;
        logic signed [`DSP_SAMPLE_W-1:0] q;
    } iq_sample_t;

    // One I/Q pair of DAC words
    typedef struct packed {
        logic signed [`DSP_DAC_W-1:0] i;
        logic signed [`DSP_DAC_W-1:0] q;
    } iq_dac_t;

    // Output gate phases
    // IDLE waits for the first symbol, FILL waits for the tap line
    typedef enum logic [1:0] {
        GATE_IDLE = 2'd0,
        GATE_FILL = 2'd1,
        GATE_RUN  = 2'd2
    } gate_state_e;

endpackage

//--- compile.f
+incdir+common
common/dsp_pkg.sv
common/coeff_pkg.sv
source/reset_sync.sv
source/upsampler.sv
fir_filter/fir_filter.sv
source/coeff_bank_decoder.sv
source/output_gate.sv
source/dsp_top.sv
verif/dsp_tb.sv

//--- fir_filter/fir_filter.sv
`timescale 1ns/1ps
`include "dsp_params.svh"

module fir_filter (
    input  logic                            clk,
    input  logic                            rst_n_sync_wire,
    input  logic signed [`DSP_SAMPLE_W-1:0] sample_i,
    input  coeff_pkg::coeff_req_t           coeff_req_i,
    output logic [`DSP_COEFF_W-1:0]         coeff_rdata_o,
    output logic signed [`DSP_ACC_W-1:0]    fir_o
);
    import coeff_pkg::*;

    logic signed [`DSP_SAMPLE_W-1:0] sample_q;
    logic signed [`DSP_SAMPLE_W-1:0] taps_q [`DSP_NUM_TAPS];
    logic signed [`DSP_COEFF_W-1:0]  coeff_q [`DSP_NUM_TAPS];
    logic signed [`DSP_ACC_W-1:0]    acc;

    // Input capture, then the tap line
    // taps_q[0] holds the newest sample
    always_ff @(posedge clk) begin
        sample_q  <= sample_i;
        taps_q[0] <= sample_q;
        for (int k = 1; k < `DSP_NUM_TAPS; k++) begin
            taps_q[k] <= taps_q[k-1];
        end
    end

    // Coefficient register file, one write port
    always_ff @(posedge clk) begin
        if (coeff_req_i.op == COEFF_WRITE) begin
            coeff_q[coeff_req_i.idx] <= coeff_req_i.wdata;
        end
    end

    // Multiply-accumulate over all taps
    // Operands are signed so each product sign-extends to the sum width
    always_comb begin
        acc = '0;
        for (int k = 0; k < `DSP_NUM_TAPS; k++) begin
            acc = acc + taps_q[k] * coeff_q[k];
        end
    end

    // Registered sum and registered read port
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            fir_o         <= '0;
            coeff_rdata_o <= '0;
        end else begin
            fir_o <= acc;
            if (coeff_req_i.op == COEFF_READ) begin
                coeff_rdata_o <= coeff_q[coeff_req_i.idx];
            end
        end
    end

    // An unknown write would poison every later output of this filter
    a_wdata_known: assert property (
        @(posedge clk) disable iff (!rst_n_sync_wire)
        (coeff_req_i.op == COEFF_WRITE) |-> !$isunknown(coeff_req_i.wdata)
    );

endmodule

//--- source/coeff_bank_decoder.sv
`timescale 1ns/1ps
`include "dsp_params.svh"

module coeff_bank_decoder (
    input  logic                    clk,
    input  logic                    rst_n_sync_wire,
    input  logic                    msg_i,
    input  logic                    coeff_rw_i,
    input  logic [`DSP_ADDR_W-1:0]  coeff_addr_i,
    input  logic [`DSP_COEFF_W-1:0] coeff_data_i,
    output coeff_pkg::coeff_req_t   i_req_o,
    output coeff_pkg::coeff_req_t   q_req_o,
    input  logic [`DSP_COEFF_W-1:0] i_rdata_i,
    input  logic [`DSP_COEFF_W-1:0] q_rdata_i,
    output logic [`DSP_COEFF_W-1:0] coeff_rdata_o
);
    import coeff_pkg::*;

    localparam logic [`DSP_ADDR_W-1:0] I_BASE = `DSP_I_BASE;
    localparam logic [`DSP_ADDR_W-1:0] Q_BASE = `DSP_Q_BASE;
    localparam logic [`DSP_ADDR_W-1:0] TAPS   = `DSP_NUM_TAPS;

    coeff_op_e               op;
    logic                    hit_i;
    logic                    hit_q;
    logic [`DSP_ADDR_W-1:0]  off_i;
    logic [`DSP_ADDR_W-1:0]  off_q;
    logic                    rd_i_q;
    logic                    rd_q_q;

    always_comb begin
        op = COEFF_NOP;
        if (msg_i) begin
            op = coeff_rw_i ? COEFF_WRITE : COEFF_READ;
        end
    end

    // Each bank is offset by its own base
    assign off_i = coeff_addr_i - I_BASE;
    assign off_q = coeff_addr_i - Q_BASE;
    assign hit_i = (coeff_addr_i >= I_BASE) && (coeff_addr_i < I_BASE + TAPS);
    assign hit_q = (coeff_addr_i >= Q_BASE) && (coeff_addr_i < Q_BASE + TAPS);

    assign i_req_o = '{op: hit_i ? op : COEFF_NOP,
                       idx: off_i[`DSP_TAP_ADDR_W-1:0], wdata: coeff_data_i};
    assign q_req_o = '{op: hit_q ? op : COEFF_NOP,
                       idx: off_q[`DSP_TAP_ADDR_W-1:0], wdata: coeff_data_i};

    // Bank select follows the filter read register by one edge
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            rd_i_q        <= 1'b0;
            rd_q_q        <= 1'b0;
            coeff_rdata_o <= '0;
        end else begin
            rd_i_q <= hit_i && (op == COEFF_READ);
            rd_q_q <= hit_q && (op == COEFF_READ);
            if (rd_i_q) begin
                coeff_rdata_o <= i_rdata_i;
            end else if (rd_q_q) begin
                coeff_rdata_o <= q_rdata_i;
            end else begin
                coeff_rdata_o <= '0;
            end
        end
    end

    // Overlapping banks would write both filters at once
    a_one_bank: assert property (
        @(posedge clk) disable iff (!rst_n_sync_wire)
        !((i_req_o.op != COEFF_NOP) && (q_req_o.op != COEFF_NOP))
    );

endmodule

//--- source/dsp_top.sv
`timescale 1ns/1ps
`include "dsp_params.svh"

module dsp_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [3:0]              sample_rate_i,
    input  logic                    new_symbol_i,
    input  dsp_pkg::iq_sample_t     symbol_i,
    input  logic                    msg_i,
    input  logic                    coeff_rw_i,
    input  logic [`DSP_ADDR_W-1:0]  coeff_addr_i,
    input  logic [`DSP_COEFF_W-1:0] coeff_data_i,
    output logic [`DSP_COEFF_W-1:0] coeff_rdata_o,
    output dsp_pkg::iq_dac_t        dac_o,
    output logic                    dac_valid_o
);
    import dsp_pkg::*;
    import coeff_pkg::*;

    logic                        rst_n_sync_wire;
    iq_sample_t                  upsampled;
    coeff_req_t                  i_req;
    coeff_req_t                  q_req;
    logic [`DSP_COEFF_W-1:0]     i_rdata;
    logic [`DSP_COEFF_W-1:0]     q_rdata;
    logic signed [`DSP_ACC_W-1:0] fir_i;
    logic signed [`DSP_ACC_W-1:0] fir_q;

    reset_sync u_reset_sync (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rst_n_sync_o (rst_n_sync_wire)
    );

    upsampler u_upsampler (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sample_rate_i   (sample_rate_i),
        .new_symbol_i    (new_symbol_i),
        .symbol_i        (symbol_i),
        .sample_o        (upsampled)
    );

    // Same filter for both rails, each with its own coefficient bank
    fir_filter i_fir (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sample_i        (upsampled.i),
        .coeff_req_i     (i_req),
        .coeff_rdata_o   (i_rdata),
        .fir_o           (fir_i)
    );

    fir_filter q_fir (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .sample_i        (upsampled.q),
        .coeff_req_i     (q_req),
        .coeff_rdata_o   (q_rdata),
        .fir_o           (fir_q)
    );

    coeff_bank_decoder u_decoder (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .msg_i           (msg_i),
        .coeff_rw_i      (coeff_rw_i),
        .coeff_addr_i    (coeff_addr_i),
        .coeff_data_i    (coeff_data_i),
        .i_req_o         (i_req),
        .q_req_o         (q_req),
        .i_rdata_i       (i_rdata),
        .q_rdata_i       (q_rdata),
        .coeff_rdata_o   (coeff_rdata_o)
    );

    output_gate u_gate (
        .clk             (clk),
        .rst_n_sync_wire (rst_n_sync_wire),
        .new_symbol_i    (new_symbol_i),
        .fir_i_i         (fir_i),
        .fir_q_i         (fir_q),
        .dac_o           (dac_o),
        .dac_valid_o     (dac_valid_o)
    );

endmodule

//--- source/output_gate.sv
`timescale 1ns/1ps
`include "dsp_params.svh"

module output_gate (
    input  logic                         clk,
    input  logic                         rst_n_sync_wire,
    input  logic                         new_symbol_i,
    input  logic signed [`DSP_ACC_W-1:0] fir_i_i,
    input  logic signed [`DSP_ACC_W-1:0] fir_q_i,
    output dsp_pkg::iq_dac_t             dac_o,
    output logic                         dac_valid_o
);
    import dsp_pkg::*;

    localparam int CNT_W = $clog2(`DSP_FILL_CYCLES + 1);
    localparam logic [CNT_W-1:0] FILL_LAST = CNT_W'(`DSP_FILL_CYCLES);

    gate_state_e      state_q;
    logic [CNT_W-1:0] fill_cnt_q;

    // Counts edges since the first symbol, one per cycle while filling
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            state_q    <= GATE_IDLE;
            fill_cnt_q <= '0;
        end else begin
            case (state_q)
                GATE_IDLE: begin
                    if (new_symbol_i) begin
                        state_q    <= GATE_FILL;
                        fill_cnt_q <= CNT_W'(1);
                    end
                end
                GATE_FILL: begin
                    if (fill_cnt_q == FILL_LAST) begin
                        state_q <= GATE_RUN;
                    end else begin
                        fill_cnt_q <= fill_cnt_q + CNT_W'(1);
                    end
                end
                GATE_RUN: begin
                    state_q <= GATE_RUN;
                end
                default: begin
                    state_q <= GATE_IDLE;
                end
            endcase
        end
    end

    assign dac_valid_o = (state_q == GATE_RUN);

    // Keep the top bits, which floors toward minus infinity
    assign dac_o.i = dac_valid_o ? fir_i_i[`DSP_ACC_W-1 -: `DSP_DAC_W] : '0;
    assign dac_o.q = dac_valid_o ? fir_q_i[`DSP_ACC_W-1 -: `DSP_DAC_W] : '0;

    // Once running, only a reset takes the output down
    a_valid_sticky: assert property (
        @(posedge clk) disable iff (!rst_n_sync_wire)
        dac_valid_o |=> dac_valid_o
    );

endmodule

//--- source/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
    input  logic clk,
    input  logic rst_n_i,
    output logic rst_n_sync_o
);

    logic [1:0] sync_q;

    // Assert at once, release after two clean edges
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign rst_n_sync_o = sync_q[1];

endmodule

//--- source/upsampler.sv
`timescale 1ns/1ps
`include "dsp_params.svh"

module upsampler (
    input  logic                clk,
    input  logic                rst_n_sync_wire,
    input  logic [3:0]          sample_rate_i,
    input  logic                new_symbol_i,
    input  dsp_pkg::iq_sample_t symbol_i,
    output dsp_pkg::iq_sample_t sample_o
);
    import dsp_pkg::*;

    iq_sample_t sample_q;
    logic [3:0] phase_q;
    logic [3:0] phase_load;

    // Rates 0 and 1 both mean one sample per symbol
    always_comb begin
        if (sample_rate_i > 4'd1) begin
            phase_load = sample_rate_i - 4'd1;
        end else begin
            phase_load = 4'd0;
        end
    end

    // Symbol on the strobe, zero on every stuffed or idle cycle
    always_ff @(posedge clk or negedge rst_n_sync_wire) begin
        if (!rst_n_sync_wire) begin
            sample_q <= '0;
            phase_q  <= 4'd0;
        end else if (new_symbol_i) begin
            sample_q <= symbol_i;
            phase_q  <= phase_load;
        end else begin
            sample_q <= '0;
            if (phase_q != 4'd0) begin
                phase_q <= phase_q - 4'd1;
            end
        end
    end

    assign sample_o = sample_q;

    // Rate changes mid-symbol would break the stuffing pattern downstream
    a_rate_stable: assert property (
        @(posedge clk) disable iff (!rst_n_sync_wire)
        (phase_q != 4'd0) |-> $stable(sample_rate_i)
    );

endmodule

//--- verif/dsp_tb.sv
`timescale 1ns/1ps
`include "dsp_params.svh"

module dsp_tb;
    import dsp_pkg::*;

    localparam real CLK_PERIOD = 8.0;
    localparam int  TAPS       = `DSP_NUM_TAPS;
    localparam int  FILL       = `DSP_FILL_CYCLES;
    localparam int  HIST       = `DSP_NUM_TAPS + 3;
    localparam int  RAND_SYMS  = 40;

    // Cycle budget of each test
    localparam int RESET_CYC   = 10 + 10;
    localparam int COEFF_CYC   = 10 * TAPS + 20;
    localparam int FILL_CYC    = FILL + 50;
    localparam int IMPULSE_CYC = TAPS + 40;
    localparam int RANDOM_CYC  = 2 * TAPS + 12 * RAND_SYMS + 60;
    localparam int TIMEOUT_CYC = RESET_CYC + COEFF_CYC + FILL_CYC + IMPULSE_CYC
                                 + RANDOM_CYC + 200;

    logic                    clk;
    logic                    rst_n_i;
    logic [3:0]              sample_rate_i;
    logic                    new_symbol_i;
    iq_sample_t              symbol_i;
    logic                    msg_i;
    logic                    coeff_rw_i;
    logic [`DSP_ADDR_W-1:0]  coeff_addr_i;
    logic [`DSP_COEFF_W-1:0] coeff_data_i;
    logic [`DSP_COEFF_W-1:0] coeff_rdata_o;
    iq_dac_t                 dac_o;
    logic                    dac_valid_o;

    // Reference model state
    int                      coef_i [TAPS];
    int                      coef_q [TAPS];
    int                      hist_i [HIST];
    int                      hist_q [HIST];
    logic [`DSP_COEFF_W-1:0] rd_stage;
    bit                      started;
    int                      since;

    string cur_test = "setup";
    int    seed = 3;
    int    err_count = 0;

    dsp_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .sample_rate_i (sample_rate_i),
        .new_symbol_i  (new_symbol_i),
        .symbol_i      (symbol_i),
        .msg_i         (msg_i),
        .coeff_rw_i    (coeff_rw_i),
        .coeff_addr_i  (coeff_addr_i),
        .coeff_data_i  (coeff_data_i),
        .coeff_rdata_o (coeff_rdata_o),
        .dac_o         (dac_o),
        .dac_valid_o   (dac_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
                     cur_test, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // An arithmetic shift keeps the top bits and floors toward minus infinity
    function automatic logic [`DSP_DAC_W-1:0] trunc_dac(input int sum);
        int shifted;
        shifted = sum >>> (`DSP_ACC_W - `DSP_DAC_W);
        return shifted[`DSP_DAC_W-1:0];
    endfunction

    function automatic logic [`DSP_COEFF_W-1:0] model_read(input logic [`DSP_ADDR_W-1:0] addr);
        if (addr >= `DSP_I_BASE && addr < `DSP_I_BASE + TAPS) begin
            return 8'(coef_i[addr - `DSP_I_BASE]);
        end else if (addr >= `DSP_Q_BASE && addr < `DSP_Q_BASE + TAPS) begin
            return 8'(coef_q[addr - `DSP_Q_BASE]);
        end
        return '0;
    endfunction

    task automatic model_write(input logic [`DSP_ADDR_W-1:0] addr,
                               input logic [`DSP_COEFF_W-1:0] data);
        if (addr >= `DSP_I_BASE && addr < `DSP_I_BASE + TAPS) begin
            coef_i[addr - `DSP_I_BASE] = int'($signed(data));
        end else if (addr >= `DSP_Q_BASE && addr < `DSP_Q_BASE + TAPS) begin
            coef_q[addr - `DSP_Q_BASE] = int'($signed(data));
        end
    endtask

    function automatic logic [`DSP_COEFF_W-1:0] i_pattern(input int k);
        return 8'(k * 16 + 3);
    endfunction

    function automatic logic [`DSP_COEFF_W-1:0] q_pattern(input int k);
        return 8'(k * 16 + 9);
    endfunction

    // Update the model at the rising edge and compare at the falling edge
    task automatic advance();
        int                    acc_i;
        int                    acc_q;
        logic [`DSP_DAC_W-1:0] exp_i;
        logic [`DSP_DAC_W-1:0] exp_q;
        logic                  exp_valid;
        logic [`DSP_COEFF_W-1:0] exp_rdata;
        @(posedge clk);
        exp_rdata = rd_stage;
        rd_stage  = (msg_i && !coeff_rw_i) ? model_read(coeff_addr_i) : '0;
        for (int k = HIST - 1; k > 0; k--) begin
            hist_i[k] = hist_i[k-1];
            hist_q[k] = hist_q[k-1];
        end
        // Zero-stuffed stream with the symbol only on its strobe
        hist_i[0] = new_symbol_i ? int'(symbol_i.i) : 0;
        hist_q[0] = new_symbol_i ? int'(symbol_i.q) : 0;
        if (started) begin
            if (since < FILL) begin
                since++;
            end
        end else if (new_symbol_i) begin
            started = 1'b1;
            since   = 0;
        end
        exp_valid = started && (since >= FILL);
        acc_i = 0;
        acc_q = 0;
        for (int k = 0; k < TAPS; k++) begin
            acc_i += coef_i[k] * hist_i[k + 3];
            acc_q += coef_q[k] * hist_q[k + 3];
        end
        exp_i = exp_valid ? trunc_dac(acc_i) : '0;
        exp_q = exp_valid ? trunc_dac(acc_q) : '0;
        @(negedge clk);
        check_value("dac_valid_o", exp_valid, dac_valid_o);
        check_value("dac_o.i", exp_i, $unsigned(dac_o.i));
        check_value("dac_o.q", exp_q, $unsigned(dac_o.q));
        check_value("coeff_rdata_o", exp_rdata, coeff_rdata_o);
    endtask

    task automatic set_idle();
        new_symbol_i = 1'b0;
        symbol_i     = '0;
        msg_i        = 1'b0;
        coeff_rw_i   = 1'b0;
        coeff_addr_i = '0;
        coeff_data_i = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) advance();
    endtask

    task automatic coeff_write(input logic [`DSP_ADDR_W-1:0] addr,
                               input logic [`DSP_COEFF_W-1:0] data);
        msg_i        = 1'b1;
        coeff_rw_i   = 1'b1;
        coeff_addr_i = addr;
        coeff_data_i = data;
        advance();
        model_write(addr, data);
        set_idle();
    endtask

    // Read data is due two edges after the request
    task automatic coeff_read(input logic [`DSP_ADDR_W-1:0] addr,
                              input logic [`DSP_COEFF_W-1:0] expected);
        msg_i        = 1'b1;
        coeff_rw_i   = 1'b0;
        coeff_addr_i = addr;
        advance();
        set_idle();
        advance();
        check_value($sformatf("read 0x%0h", addr), expected, coeff_rdata_o);
    endtask

    task automatic send_symbol(input logic [3:0] i_val, input logic [3:0] q_val);
        new_symbol_i = 1'b1;
        symbol_i.i   = i_val;
        symbol_i.q   = q_val;
        advance();
        set_idle();
    endtask

    task automatic readback_all();
        for (int k = 0; k < TAPS; k++) begin
            coeff_read(`DSP_I_BASE + k, i_pattern(k));
            coeff_read(`DSP_Q_BASE + k, q_pattern(k));
        end
    endtask

    task automatic check_gate_closed();
        check_value("dac_valid_o", 0, dac_valid_o);
        check_value("dac_o.i", 0, $unsigned(dac_o.i));
        check_value("dac_o.q", 0, $unsigned(dac_o.q));
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        idle_cycles(4);
        check_gate_closed();
        check_value("coeff_rdata_o", 0, coeff_rdata_o);
    endtask

    task automatic test_coeff_access();
        cur_test = "test_coeff_access";
        for (int k = 0; k < TAPS; k++) begin
            coeff_write(`DSP_I_BASE + k, i_pattern(k));
            coeff_write(`DSP_Q_BASE + k, q_pattern(k));
        end
        readback_all();
        // Unmapped addresses read as zero
        coeff_read(200, 0);
        coeff_read(0, 0);
        coeff_read(`DSP_I_BASE + TAPS, 0);
        coeff_read(`DSP_Q_BASE - 1, 0);
        coeff_write(200, 8'h5a);
        coeff_write(`DSP_Q_BASE + TAPS, 8'ha5);
        readback_all();
        coeff_read(200, 0);
    endtask

    // A nonzero symbol drives the filters while the gate must still hold zero
    task automatic test_fill_gate();
        cur_test = "test_fill_gate";
        sample_rate_i = 4'd1;
        send_symbol(4'd7, 4'd9);
        check_gate_closed();
        repeat (FILL - 1) begin
            advance();
            check_gate_closed();
        end
        repeat (20) begin
            advance();
            check_value("dac_valid_o", 1, dac_valid_o);
        end
    endtask

    task automatic test_impulse();
        cur_test = "test_impulse";
        sample_rate_i = 4'd4;
        send_symbol(4'd1, 4'd0);
        idle_cycles(2);
        for (int j = 3; j < TAPS + 3; j++) begin
            if (j % 4 == 0) begin
                new_symbol_i = 1'b1;
                symbol_i     = '0;
            end
            advance();
            set_idle();
            check_value($sformatf("dac_o.i tap %0d", j - 3),
                        trunc_dac(int'($signed(i_pattern(j - 3)))), $unsigned(dac_o.i));
            check_value("dac_o.q", 0, $unsigned(dac_o.q));
        end
        idle_cycles(HIST + 2);
    endtask

    task automatic test_random_stream();
        int rates [3];
        int rnd;
        cur_test = "test_random_stream";
        rates = '{1, 3, 8};
        for (int k = 0; k < TAPS; k++) begin
            rnd = $random(seed);
            coeff_write(`DSP_I_BASE + k, rnd[7:0]);
            rnd = $random(seed);
            coeff_write(`DSP_Q_BASE + k, rnd[7:0]);
        end
        // Rate only changes once the stuffing counter has drained
        for (int r = 0; r < 3; r++) begin
            sample_rate_i = rates[r];
            repeat (RAND_SYMS) begin
                rnd = $random(seed);
                send_symbol(rnd[3:0], rnd[7:4]);
                idle_cycles(rates[r] - 1);
            end
            idle_cycles(4);
        end
        idle_cycles(HIST);
        check_value("dac_valid_o", 1, dac_valid_o);
    endtask

    initial begin
        rst_n_i       = 1'b0;
        sample_rate_i = 4'd1;
        set_idle();
        for (int k = 0; k < TAPS; k++) begin
            coef_i[k] = 0;
            coef_q[k] = 0;
        end
        for (int k = 0; k < HIST; k++) begin
            hist_i[k] = 0;
            hist_q[k] = 0;
        end
        rd_stage = '0;
        started  = 1'b0;
        since    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i  = 1'b1;

        test_reset();
        test_coeff_access();
        test_fill_gate();
        test_impulse();
        test_random_stream();

        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
